//--- filelist.f
+incdir+.
sdram_pkg.sv
video_pkg.sv
line_timer.sv
rom_loader.sv
rom_slot.sv
sdram_arbiter.sv
sf_rom_system.sv
tb_sf_rom_system.sv

//--- line_timer.sv
////////////////////
// Line and frame counter with blanking and sync
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sf_defines.svh"

module line_timer (
    input  wire                clk24,
    input  wire                reset,
    output logic               lhbl,
    output logic               lvbl,
    output logic               hs,
    output logic               vs,
    output video_pkg::hcount_t h,
    output video_pkg::vcount_t v
);

    video_pkg::hcount_t h_nxt;
    video_pkg::vcount_t v_nxt;

    always_comb begin
        h_nxt = h + 9'd1;
        v_nxt = v;
        if (h == `SF_HCNT_END) begin
            h_nxt = '0;
            v_nxt = (v == `SF_VCNT_END) ? '0 : v + 9'd1;
        end
    end

    // Windows are decoded from the next count so they line up with h and v
    always_ff @(posedge clk24) begin
        if (reset) begin
            h    <= '0;
            v    <= '0;
            lhbl <= 1'b0;
            lvbl <= 1'b0;
            // Position zero sits inside the sync pulse
            hs   <= 1'b1;
            vs   <= 1'b0;
        end else begin
            h    <= h_nxt;
            v    <= v_nxt;
            lhbl <= !(h_nxt >= `SF_HB_START || h_nxt < `SF_HB_END);
            lvbl <= !(v_nxt >= `SF_VB_START || v_nxt < `SF_VB_END);
            hs   <= h_nxt >= `SF_HS_START || h_nxt < `SF_HS_END;
            vs   <= v_nxt >= `SF_VS_START;
        end
    end

    a_v_range: assert property (@(posedge clk24) disable iff (reset)
        v <= `SF_VCNT_END);

endmodule

`default_nettype wire

//--- rom_loader.sv
////////////////////
// Download byte to masked SDRAM word write
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sf_defines.svh"

module rom_loader (
    input  wire                      clk24,
    input  wire                      reset,
    input  wire                      downloading,
    input  wire  [24:0]              ioctl_addr,
    input  wire  [7:0]               ioctl_data,
    input  wire                      ioctl_wr,
    output sdram_pkg::sdram_addr_t   prog_addr,
    output logic [7:0]               prog_data,
    output logic [1:0]               prog_mask,
    output logic                     prog_we
);

    sdram_pkg::sdram_addr_t pre_addr;
    logic                   in_prom;
    logic                   in_obj;

    assign pre_addr = ioctl_addr[22:1];
    assign in_prom  = ioctl_addr >= `SF_PROM_START;
    assign in_obj   = (pre_addr >= `SF_OBJ_OFFSET) && !in_prom;

    always_ff @(posedge clk24) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else begin
            prog_we <= downloading && ioctl_wr && !in_prom;
        end
    end

    // Object graphics get bit 5 moved down next to bit 0
    always_ff @(posedge clk24) begin
        if (downloading && ioctl_wr) begin
            prog_addr <= in_obj ? {pre_addr[21:6], pre_addr[4:1], pre_addr[5], pre_addr[0]}
                                : pre_addr;
            prog_data <= ioctl_data;
            // Even bytes land in the low half
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    a_we_in_dwnld: assert property (@(posedge clk24) disable iff (reset)
        prog_we |-> downloading);

endmodule

`default_nettype wire

//--- rom_slot.sv
////////////////////
// Single cached SDRAM read slot
////////////////////
`timescale 1ns/1ps
`default_nettype none

module rom_slot #(
    parameter type                    payload_t = logic [15:0],
    parameter int                     AW        = 19,
    parameter sdram_pkg::sdram_addr_t OFFSET    = '0
) (
    input  wire                    clk24,
    input  wire                    reset,
    input  wire                    downloading,
    input  wire                    cs,
    input  wire  [AW-1:0]          addr,
    input  wire                    load,
    input  sdram_pkg::sdram_data_t data_read,
    output payload_t               dout,
    output logic                   ok,
    output logic                   req,
    output sdram_pkg::sdram_addr_t sdram_addr
);

    localparam int DW = $bits(payload_t);

    logic          valid;
    logic [AW-1:0] cached_addr;
    payload_t      fill;
    logic          hit;

    // Byte slots address bytes, the SDRAM holds 16-bit words
    generate
        if (DW == 8) begin : g_byte
            assign sdram_addr = OFFSET + sdram_pkg::sdram_addr_t'(addr[AW-1:1]);
            assign fill       = addr[0] ? data_read[15:8] : data_read[7:0];
        end else begin : g_word
            assign sdram_addr = OFFSET + sdram_pkg::sdram_addr_t'(addr);
            assign fill       = data_read[DW-1:0];
        end
    endgenerate

    assign hit = valid && (cached_addr == addr);
    assign ok  = cs && hit;
    assign req = cs && !hit;

    always_ff @(posedge clk24) begin
        if (reset || downloading) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk24) begin
        if (load) begin
            cached_addr <= addr;
            dout        <= fill;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then look for the pass line
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_sf_rom_system \
    && ./obj_dir/Vtb_sf_rom_system | tee sim.log
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- sdram_arbiter.sv
////////////////////
// Fixed priority read arbiter for three slots
////////////////////
`timescale 1ns/1ps
`default_nettype none

module sdram_arbiter (
    input  wire                    clk24,
    input  wire                    reset,
    input  wire                    downloading,
    input  wire                    sdram_ack,
    input  wire                    data_rdy,
    input  wire  [2:0]             slot_req,
    input  sdram_pkg::sdram_addr_t slot_addr0,
    input  sdram_pkg::sdram_addr_t slot_addr1,
    input  sdram_pkg::sdram_addr_t slot_addr2,
    output logic [2:0]             slot_load,
    output logic                   sdram_req,
    output sdram_pkg::sdram_addr_t sdram_addr
);

    sdram_pkg::arb_state_t  state;
    logic [1:0]             gnt;
    logic [1:0]             sel;
    sdram_pkg::sdram_addr_t sel_addr;

    // Main first, then sound, then map
    always_comb begin
        if (slot_req[0]) begin
            sel      = 2'd0;
            sel_addr = slot_addr0;
        end else if (slot_req[1]) begin
            sel      = 2'd1;
            sel_addr = slot_addr1;
        end else begin
            sel      = 2'd2;
            sel_addr = slot_addr2;
        end
    end

    // Load fires with data_rdy so the slot is filled before idle looks again
    always_comb begin
        slot_load = 3'b000;
        if (state == sdram_pkg::arb_wait && data_rdy) begin
            slot_load[gnt] = 1'b1;
        end
    end

    ////////////////////
    // State machine
    always_ff @(posedge clk24) begin
        if (reset) begin
            state     <= sdram_pkg::arb_idle;
            sdram_req <= 1'b0;
            gnt       <= 2'd0;
        end else begin
            case (state)
                sdram_pkg::arb_idle: begin
                    if (!downloading && |slot_req) begin
                        gnt       <= sel;
                        sdram_req <= 1'b1;
                        state     <= sdram_pkg::arb_req;
                    end
                end
                sdram_pkg::arb_req: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= sdram_pkg::arb_wait;
                    end
                end
                sdram_pkg::arb_wait: begin
                    if (data_rdy) begin
                        state <= sdram_pkg::arb_idle;
                    end
                end
                default: begin
                    state     <= sdram_pkg::arb_idle;
                    sdram_req <= 1'b0;
                end
            endcase
        end
    end

    // Address is held for the whole access
    always_ff @(posedge clk24) begin
        if (state == sdram_pkg::arb_idle && !downloading && |slot_req) begin
            sdram_addr <= sel_addr;
        end
    end

    // The SDRAM may only acknowledge a pending request
    a_ack_on_req: assert property (@(posedge clk24) disable iff (reset)
        sdram_ack |-> sdram_req);

endmodule

`default_nettype wire

//--- sdram_pkg.sv
////////////////////
// SDRAM address and data types
// Arbiter state encoding
////////////////////
`default_nettype none

`include "sf_defines.svh"

package sdram_pkg;

    // One SDRAM word address
    typedef logic [`SF_SDRAM_AW-1:0] sdram_addr_t;

    // Read data comes back as two 16-bit words
    typedef logic [31:0] sdram_data_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_req,
        arb_wait
    } arb_state_t;

endpackage

`default_nettype wire

//--- sf_defines.svh
////////////////////
// Address widths, SDRAM region offsets and PROM start
// Line and frame timer limits
////////////////////
`ifndef SF_DEFINES_SVH
`define SF_DEFINES_SVH

// SDRAM word address and slot address widths
`define SF_SDRAM_AW     22
`define SF_MAIN_AW      19
`define SF_SND_AW       15
`define SF_MAP_AW       16

// Region offsets in SDRAM words
`define SF_MAIN_OFFSET  22'h00_0000
`define SF_SND_OFFSET   22'h03_0000
`define SF_MAP_OFFSET   22'h05_4800
`define SF_OBJ_OFFSET   22'h13_6800

// Byte address of the first PROM byte
`define SF_PROM_START   25'h42_D000

// Horizontal timing, in clk24 cycles
`define SF_HB_START     9'h1C7
`define SF_HB_END       9'h04F
`define SF_HCNT_END     9'h1FF
`define SF_HS_START     9'h1F8
`define SF_HS_END       9'h020

// Vertical timing, in lines
`define SF_VB_START     9'h0F0
`define SF_VB_END       9'h010
`define SF_VCNT_END     9'h0FF
`define SF_VS_START     9'h0F8

`endif

//--- sf_rom_system.sv
////////////////////
// ROM memory side: timer, loader, read slots and arbiter
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sf_defines.svh"

module sf_rom_system (
    input  wire                      clk24,
    input  wire                      reset,
    input  wire                      downloading,
    // Download port
    input  wire  [24:0]              ioctl_addr,
    input  wire  [7:0]               ioctl_data,
    input  wire                      ioctl_wr,
    output sdram_pkg::sdram_addr_t   prog_addr,
    output logic [7:0]               prog_data,
    output logic [1:0]               prog_mask,
    output logic                     prog_we,
    // Requesters
    input  wire                      main_cs,
    input  wire  [`SF_MAIN_AW-1:0]   main_addr,
    output logic [15:0]              main_data,
    output logic                     main_ok,
    input  wire                      snd_cs,
    input  wire  [`SF_SND_AW-1:0]    snd_addr,
    output logic [7:0]               snd_data,
    output logic                     snd_ok,
    input  wire                      map_cs,
    input  wire  [`SF_MAP_AW-1:0]    map_addr,
    output logic [31:0]              map_data,
    output logic                     map_ok,
    // SDRAM
    output logic                     sdram_req,
    output sdram_pkg::sdram_addr_t   sdram_addr,
    input  wire                      sdram_ack,
    input  wire                      data_rdy,
    input  sdram_pkg::sdram_data_t   data_read,
    // Video timing
    output logic                     lhbl,
    output logic                     lvbl,
    output logic                     hs,
    output logic                     vs
);

    logic [2:0]             slot_req;
    logic [2:0]             slot_load;
    sdram_pkg::sdram_addr_t main_sdram_addr;
    sdram_pkg::sdram_addr_t snd_sdram_addr;
    sdram_pkg::sdram_addr_t map_sdram_addr;
    logic                   map_cs_gated;
    logic [31:0]            map_raw;

    // Map reads only outside vertical blank
    assign map_cs_gated = map_cs & lvbl;
    assign map_data     = {map_raw[15:0], map_raw[31:16]};

    line_timer u_timer (
        .clk24 (clk24), .reset (reset),
        .lhbl  (lhbl),  .lvbl  (lvbl), .hs (hs), .vs (vs),
        .h     (),      .v     ()
    );

    rom_loader u_loader (
        .clk24      (clk24),      .reset      (reset),      .downloading (downloading),
        .ioctl_addr (ioctl_addr), .ioctl_data (ioctl_data), .ioctl_wr    (ioctl_wr),
        .prog_addr  (prog_addr),  .prog_data  (prog_data),  .prog_mask   (prog_mask),
        .prog_we    (prog_we)
    );

    ////////////////////
    // Read slots
    rom_slot #(.payload_t (logic [15:0]), .AW (`SF_MAIN_AW), .OFFSET (`SF_MAIN_OFFSET)) u_main (
        .clk24 (clk24), .reset (reset), .downloading (downloading),
        .cs (main_cs), .addr (main_addr), .load (slot_load[0]), .data_read (data_read),
        .dout (main_data), .ok (main_ok), .req (slot_req[0]), .sdram_addr (main_sdram_addr)
    );

    rom_slot #(.payload_t (logic [7:0]), .AW (`SF_SND_AW), .OFFSET (`SF_SND_OFFSET)) u_snd (
        .clk24 (clk24), .reset (reset), .downloading (downloading),
        .cs (snd_cs), .addr (snd_addr), .load (slot_load[1]), .data_read (data_read),
        .dout (snd_data), .ok (snd_ok), .req (slot_req[1]), .sdram_addr (snd_sdram_addr)
    );

    rom_slot #(.payload_t (logic [31:0]), .AW (`SF_MAP_AW), .OFFSET (`SF_MAP_OFFSET)) u_map (
        .clk24 (clk24), .reset (reset), .downloading (downloading),
        .cs (map_cs_gated), .addr (map_addr), .load (slot_load[2]), .data_read (data_read),
        .dout (map_raw), .ok (map_ok), .req (slot_req[2]), .sdram_addr (map_sdram_addr)
    );

    sdram_arbiter u_arb (
        .clk24      (clk24),           .reset      (reset),          .downloading (downloading),
        .sdram_ack  (sdram_ack),       .data_rdy   (data_rdy),       .slot_req    (slot_req),
        .slot_addr0 (main_sdram_addr), .slot_addr1 (snd_sdram_addr), .slot_addr2  (map_sdram_addr),
        .slot_load  (slot_load),       .sdram_req  (sdram_req),      .sdram_addr  (sdram_addr)
    );

endmodule

`default_nettype wire

//--- tb_sf_rom_system.sv
////////////////////
// Testbench for the ROM memory side
// SDRAM model, reference function, checker and watchdog
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "sf_defines.svh"

module tb_sf_rom_system;

    localparam int LINE_CYCLES   = int'(`SF_HCNT_END) + 1;
    localparam int FRAME_CYCLES  = LINE_CYCLES * (int'(`SF_VCNT_END) + 1);
    localparam int HBLANK_CYCLES = LINE_CYCLES - int'(`SF_HB_START) + int'(`SF_HB_END);
    localparam int HSYNC_CYCLES  = LINE_CYCLES - int'(`SF_HS_START) + int'(`SF_HS_END);
    localparam int VSYNC_CYCLES  = LINE_CYCLES * (int'(`SF_VCNT_END) + 1 - int'(`SF_VS_START));

    logic                   clk24;
    logic                   reset;
    logic                   downloading;
    logic [24:0]            ioctl_addr;
    logic [7:0]             ioctl_data;
    logic                   ioctl_wr;
    sdram_pkg::sdram_addr_t prog_addr;
    logic [7:0]             prog_data;
    logic [1:0]             prog_mask;
    logic                   prog_we;
    logic                   main_cs;
    logic [`SF_MAIN_AW-1:0] main_addr;
    logic [15:0]            main_data;
    logic                   main_ok;
    logic                   snd_cs;
    logic [`SF_SND_AW-1:0]  snd_addr;
    logic [7:0]             snd_data;
    logic                   snd_ok;
    logic                   map_cs;
    logic [`SF_MAP_AW-1:0]  map_addr;
    logic [31:0]            map_data;
    logic                   map_ok;
    logic                   sdram_req;
    sdram_pkg::sdram_addr_t sdram_addr;
    logic                   sdram_ack;
    logic                   data_rdy;
    sdram_pkg::sdram_data_t data_read;
    logic                   lhbl;
    logic                   lvbl;
    logic                   hs;
    logic                   vs;

    integer seed = 47639;
    int     req_count = 0;
    logic   req_q = 1'b0;
    logic   main_ok_q = 1'b0;
    logic   snd_ok_q = 1'b0;
    logic   map_ok_q = 1'b0;

    sf_rom_system UUT (.*);

    initial begin
        clk24 = 1'b0;
        forever #50 clk24 = ~clk24;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // Expected payload per slot, as seen on the top level data port
    function automatic logic [31:0] ref_data(input int slot, input logic [18:0] a);
        sdram_pkg::sdram_addr_t w;
        logic [15:0]            lo;
        case (slot)
            0:       w = `SF_MAIN_OFFSET + 22'(a);
            1:       w = `SF_SND_OFFSET + 22'(a[14:1]);
            default: w = `SF_MAP_OFFSET + 22'(a[15:0]);
        endcase
        lo = w[15:0] ^ 16'hA5C3;
        case (slot)
            0:       return {16'h0000, lo};
            1:       return {24'h000000, a[0] ? lo[15:8] : lo[7:0]};
            default: return {lo, ~lo};
        endcase
    endfunction

    ////////////////////
    // SDRAM model

    function automatic sdram_pkg::sdram_data_t sdram_word(input sdram_pkg::sdram_addr_t w);
        logic [15:0] lo;
        lo = w[15:0] ^ 16'hA5C3;
        return {~lo, lo};
    endfunction

    initial begin : sdram_model
        sdram_pkg::sdram_addr_t addr;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk24);
            if (sdram_req) begin
                repeat ($random(seed) & 3) @(negedge clk24);
                addr      = sdram_addr;
                sdram_ack = 1'b1;
                @(negedge clk24);
                sdram_ack = 1'b0;
                repeat ($random(seed) & 3) @(negedge clk24);
                data_read = sdram_word(addr);
                data_rdy  = 1'b1;
                @(negedge clk24);
                data_rdy  = 1'b0;
            end
        end
    end

    // New SDRAM accesses
    always @(posedge clk24) begin
        if (sdram_req && !req_q) begin
            req_count++;
        end
        req_q = sdram_req;
    end

    // Data is checked once per rising ok
    always @(posedge clk24) begin
        if (main_ok && !main_ok_q) begin
            check("main_data", 32'(main_data), ref_data(0, main_addr));
        end
        if (snd_ok && !snd_ok_q) begin
            check("snd_data", 32'(snd_data), ref_data(1, 19'(snd_addr)));
        end
        if (map_ok && !map_ok_q) begin
            check("map_data", map_data, ref_data(2, 19'(map_addr)));
        end
        main_ok_q = main_ok;
        snd_ok_q  = snd_ok;
        map_ok_q  = map_ok;
    end

    initial begin : watchdog
        repeat (3 * FRAME_CYCLES) @(posedge clk24);
        $display("Timeout: the tests did not finish within three frames");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    function automatic logic slot_ok(input int slot);
        case (slot)
            0:       return main_ok;
            1:       return snd_ok;
            default: return map_ok;
        endcase
    endfunction

    task automatic read_slot(input int slot, input logic [18:0] a);
        @(negedge clk24);
        case (slot)
            0: begin
                main_addr = a;
                main_cs   = 1'b1;
            end
            1: begin
                snd_addr = a[14:0];
                snd_cs   = 1'b1;
            end
            default: begin
                map_addr = a[15:0];
                map_cs   = 1'b1;
            end
        endcase
        @(negedge clk24);
        while (!slot_ok(slot)) @(negedge clk24);
        // One more rising edge so the compare process sees ok
        @(negedge clk24);
        main_cs = 1'b0;
        snd_cs  = 1'b0;
        map_cs  = 1'b0;
    endtask

    // One loader strobe, then the registered write is compared
    task automatic load_byte(input logic [24:0] a, input logic [7:0] d);
        sdram_pkg::sdram_addr_t raw;
        sdram_pkg::sdram_addr_t w;
        logic                   expect_we;
        raw = a[22:1];
        w   = raw;
        // Object words keep bits 21..6 and 0, bits 4..1 move up and bit 5 drops to 1
        if (raw >= `SF_OBJ_OFFSET) begin
            w[5:2] = raw[4:1];
            w[1]   = raw[5];
        end
        expect_we = a < `SF_PROM_START;
        @(negedge clk24);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(negedge clk24);
        ioctl_wr = 1'b0;
        check("prog_we", 32'(prog_we), 32'(expect_we));
        if (expect_we) begin
            check("prog_addr", 32'(prog_addr), 32'(w));
            check("prog_mask", 32'(prog_mask), a[0] ? 32'h1 : 32'h2);
            check("prog_data", 32'(prog_data), 32'(d));
        end
    endtask

    ////////////////////
    // Stimulus

    initial begin : stimulus
        int count;
        int lhbl_low;
        int hs_high;
        int vs_high;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        map_cs      = 1'b0;
        map_addr    = '0;
        repeat (10) @(posedge clk24);
        @(negedge clk24);
        reset = 1'b0;
        check("sdram_req", 32'(sdram_req), 0);
        check("prog_we", 32'(prog_we), 0);
        check("main_ok", 32'(main_ok), 0);
        check("snd_ok", 32'(snd_ok), 0);
        check("map_ok", 32'(map_ok), 0);

        // Map request held off by vertical blank
        count    = req_count;
        map_addr = 16'h1357;
        map_cs   = 1'b1;
        check("lvbl", 32'(lvbl), 0);
        @(negedge clk24);
        while (!lvbl) begin
            check("map_ok", 32'(map_ok), 0);
            check("sdram_req_count", req_count, count);
            @(negedge clk24);
        end
        while (!map_ok) @(negedge clk24);
        @(negedge clk24);
        map_cs = 1'b0;

        // Blank and sync widths over one line
        lhbl_low = 0;
        hs_high  = 0;
        repeat (LINE_CYCLES) begin
            @(negedge clk24);
            if (!lhbl) lhbl_low++;
            if (hs) hs_high++;
        end
        check("lhbl_low_cycles", lhbl_low, HBLANK_CYCLES);
        check("hs_high_cycles", hs_high, HSYNC_CYCLES);

        // Vertical sync width over one frame
        vs_high = 0;
        repeat (FRAME_CYCLES) begin
            @(negedge clk24);
            if (vs) vs_high++;
        end
        check("vs_high_cycles", vs_high, VSYNC_CYCLES);

        // Main reads, the repeat must hit the cache
        count = req_count;
        read_slot(0, 19'h12345);
        check("sdram_req_count", req_count, count + 1);
        read_slot(0, 19'h12345);
        check("sdram_req_count", req_count, count + 1);
        read_slot(0, 19'h7FFF0);

        read_slot(1, 19'h01234);
        read_slot(1, 19'h01235);
        read_slot(2, 19'h0ABCD);

        ////////////////////
        // Download window
        @(negedge clk24);
        downloading = 1'b1;
        load_byte(25'h000100, 8'h3C);
        load_byte(25'h000101, 8'hC3);
        load_byte(25'h26D0A5, 8'h5A);
        load_byte(`SF_PROM_START + 25'h10, 8'hFF);

        count = req_count;
        @(negedge clk24);
        main_addr = 19'h7FFF0;
        main_cs   = 1'b1;
        repeat (16) @(negedge clk24);
        check("main_ok", 32'(main_ok), 0);
        check("sdram_req_count", req_count, count);
        downloading = 1'b0;
        // Cache was flushed, so the old address goes back to SDRAM
        @(negedge clk24);
        while (!main_ok) @(negedge clk24);
        check("sdram_req_count", req_count, count + 1);
        @(negedge clk24);
        main_cs = 1'b0;

        repeat (4) @(posedge clk24);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- video_pkg.sv
////////////////////
// Horizontal and vertical count types
////////////////////
`default_nettype none

package video_pkg;

    typedef logic [8:0] hcount_t;
    typedef logic [8:0] vcount_t;

endpackage

`default_nettype wire
